/* lsu_pkg.sv */
// ------------------------------------------------------------
// Shared types, memory map and sizes of the load and store
// path: data word, load size encoding and buffer dimensions
// ------------------------------------------------------------

package lsu_pkg;

    // One data or address word of the core
    typedef logic [31:0] data_word_t;

    // Load size, the sign extension is a separate flag
    typedef enum logic [1:0] {
        LDB = 2'b00,
        LDH = 2'b01,
        LDW = 2'b10
    } ldu_uop_e;

    // ------------------------------------------------------------
    // Memory map
    // ------------------------------------------------------------

    // Inclusive byte bounds of the region reserved to privileged code
    localparam data_word_t PRIVATE_REGION_START = 32'h0000_0380;
    localparam data_word_t PRIVATE_REGION_END   = 32'h0000_03FF;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------

    // Data memory depth in words, addresses wrap on bits 9 to 2
    localparam int MEM_WORDS   = 256;
    localparam int MEM_ADDR_W  = $clog2(MEM_WORDS);

    // Cycles from a read strobe to the read valid pulse
    localparam int MEM_LATENCY = 2;

    // Store buffer entries, the depth must be a power of two
    localparam int STB_DEPTH   = 4;
    localparam int STB_PTR_W   = $clog2(STB_DEPTH);
    localparam int STB_CNT_W   = STB_PTR_W + 1;

endpackage : lsu_pkg

/* store_buffer.sv */
// ------------------------------------------------------------
// Store buffer: circular FIFO of pending word stores with
// youngest-first forwarding and drain towards the memory
// ------------------------------------------------------------

`timescale 1ns/10ps

module store_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // New store from the core
    input  logic                push_i,
    input  lsu_pkg::data_word_t push_addr_i,
    input  lsu_pkg::data_word_t push_data_i,
    // Forwarding search from the load unit
    input  lsu_pkg::data_word_t search_addr_i,
    // Memory port granted by the top level arbiter
    input  logic                drain_grant_i,
    output logic                drain_req_o,
    output lsu_pkg::data_word_t drain_addr_o,
    output lsu_pkg::data_word_t drain_data_o,
    output logic                foward_match_o,
    output lsu_pkg::data_word_t foward_data_o,
    output logic                full_o,
    output logic                empty_o
);

    // Entry storage, indexed by the head and tail pointers
    lsu_pkg::data_word_t addr_q [lsu_pkg::STB_DEPTH];
    lsu_pkg::data_word_t data_q [lsu_pkg::STB_DEPTH];

    logic [lsu_pkg::STB_PTR_W-1:0] head_q;
    logic [lsu_pkg::STB_PTR_W-1:0] tail_q;
    logic [lsu_pkg::STB_CNT_W-1:0] count_q;

    logic push_en;
    logic pop_en;

    // The count reaches STB_DEPTH only when its top bit is set
    assign full_o  = count_q[lsu_pkg::STB_PTR_W];
    assign empty_o = (count_q == '0);

    // A store strobed while full is dropped
    assign push_en = push_i & ~full_o;
    assign pop_en  = drain_grant_i & ~empty_o;

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------

    // Pointers wrap naturally because the depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_en) begin
                head_q <= head_q + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry is visible to the search one cycle after the push
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            addr_q[tail_q] <= push_addr_i;
            data_q[tail_q] <= push_data_i;
        end
    end

    // The oldest entry is always offered to the memory
    assign drain_req_o  = ~empty_o;
    assign drain_addr_o = addr_q[head_q];
    assign drain_data_o = data_q[head_q];

    // ------------------------------------------------------------
    // Forwarding search
    // ------------------------------------------------------------

    // Walk from oldest to youngest so that a later match overrides
    always_comb begin : forward_search
        logic [lsu_pkg::STB_PTR_W-1:0] idx;
        foward_match_o = 1'b0;
        foward_data_o  = '0;
        for (int unsigned i = 0; i < lsu_pkg::STB_DEPTH; i++) begin
            idx = head_q + i[lsu_pkg::STB_PTR_W-1:0];
            // Only occupied slots take part, compared as word addresses
            if ((count_q > i[lsu_pkg::STB_CNT_W-1:0]) &&
                (addr_q[idx][31:2] == search_addr_i[31:2])) begin
                foward_match_o = 1'b1;
                foward_data_o  = data_q[idx];
            end
        end
    end : forward_search

endmodule : store_buffer

/* data_memory.sv */
// ------------------------------------------------------------
// Single port word memory with a write strobe and a read
// response delayed by a fixed latency
// ------------------------------------------------------------

`timescale 1ns/10ps

module data_memory (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                read_req_i,
    input  lsu_pkg::data_word_t read_addr_i,
    input  logic                write_i,
    input  lsu_pkg::data_word_t write_addr_i,
    input  lsu_pkg::data_word_t write_data_i,
    output logic                read_valid_o,
    output lsu_pkg::data_word_t read_data_o
);

    lsu_pkg::data_word_t mem_q [lsu_pkg::MEM_WORDS];

    // Response line, one stage per cycle of latency
    logic [lsu_pkg::MEM_LATENCY-1:0] valid_q;
    lsu_pkg::data_word_t             data_q [lsu_pkg::MEM_LATENCY];

    // Byte addresses drop the offset and wrap on the array size
    logic [lsu_pkg::MEM_ADDR_W-1:0] read_index;
    logic [lsu_pkg::MEM_ADDR_W-1:0] write_index;

    assign read_index  = read_addr_i[lsu_pkg::MEM_ADDR_W+1:2];
    assign write_index = write_addr_i[lsu_pkg::MEM_ADDR_W+1:2];

    // Reset sweeps every word to zero, afterwards writes land on the edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < lsu_pkg::MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (write_i) begin
            mem_q[write_index] <= write_data_i;
        end
    end

    // Valid bits shift towards the output, the first stage samples the strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[lsu_pkg::MEM_LATENCY-2:0], read_req_i};
        end
    end

    // The array is read at the strobe edge and the word then travels down the line
    always_ff @(posedge clk_i) begin
        data_q[0] <= mem_q[read_index];
        for (int i = 1; i < lsu_pkg::MEM_LATENCY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign read_valid_o = valid_q[lsu_pkg::MEM_LATENCY-1];
    assign read_data_o  = data_q[lsu_pkg::MEM_LATENCY-1];

endmodule : data_memory

/* load_unit.sv */
// ------------------------------------------------------------
// Load unit: access checks, forwarding select, stall hold
// and sub-word slicing with zero or sign extension
// ------------------------------------------------------------

`timescale 1ns/10ps

module load_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                privilege_i,
    input  logic                valid_operation_i,
    input  lsu_pkg::data_word_t load_address_i,
    input  lsu_pkg::ldu_uop_e   operation_i,
    input  logic                signed_load_i,
    input  logic                foward_match_i,
    input  lsu_pkg::data_word_t foward_data_i,
    input  logic                buffer_empty_i,
    input  logic                mem_valid_i,
    input  lsu_pkg::data_word_t mem_data_i,
    output logic                mem_request_o,
    output lsu_pkg::data_word_t mem_address_o,
    output lsu_pkg::data_word_t data_loaded_o,
    output logic                data_valid_o,
    output logic                misaligned_o,
    output logic                illegal_access_o,
    output logic                idle_o
);

    typedef enum logic [1:0] {IDLE, WAIT_MEMORY, WAIT_BUFFER_DRAIN, WAIT_STALL} state_e;

    state_e              state_q, state_d;
    lsu_pkg::data_word_t address_q;
    lsu_pkg::ldu_uop_e   operation_q;
    logic                signed_q;
    lsu_pkg::data_word_t saved_data_q, save_data;
    logic                saved_mis_q, saved_ill_q;
    logic                save_en, save_mis, save_ill;
    logic                misaligned, illegal, accept_en;
    lsu_pkg::data_word_t data_selected, data_sliced;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;

    // ------------------------------------------------------------
    // Access checks on the incoming load
    // ------------------------------------------------------------

    // Half words need 2-byte alignment and words 4-byte alignment
    assign misaligned = ((operation_i == lsu_pkg::LDH) & load_address_i[0]) |
                        ((operation_i == lsu_pkg::LDW) & (load_address_i[1:0] != 2'b00));

    // Unprivileged code may not read the private region
    assign illegal = ~privilege_i &
                     (load_address_i >= lsu_pkg::PRIVATE_REGION_START) &
                     (load_address_i <= lsu_pkg::PRIVATE_REGION_END);

    assign accept_en = valid_operation_i & (state_q == IDLE) & ~misaligned & ~illegal;

    // Good loads keep their address and size for the later stages
    always_ff @(posedge clk_i) begin
        if (accept_en) begin
            address_q   <= load_address_i;
            operation_q <= operation_i;
            signed_q    <= signed_load_i;
        end
    end

    // Hold register for a forwarded word, a stalled response or a stalled exception
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            saved_mis_q <= 1'b0;
            saved_ill_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (save_en) begin
                saved_mis_q <= save_mis;
                saved_ill_q <= save_ill;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (save_en) begin
            saved_data_q <= save_data;
        end
    end

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------

    always_comb begin : fsm_logic
        state_d          = state_q;
        mem_request_o    = 1'b0;
        mem_address_o    = address_q;
        data_valid_o     = 1'b0;
        misaligned_o     = 1'b0;
        illegal_access_o = 1'b0;
        data_selected    = '0;
        save_en          = 1'b0;
        save_data        = mem_data_i;
        save_mis         = 1'b0;
        save_ill         = 1'b0;
        case (state_q)
            IDLE: begin
                // The request goes out in the acceptance cycle for a word miss
                mem_address_o = load_address_i;
                if (valid_operation_i && (misaligned || illegal)) begin
                    // Exceptions answer at once unless the core is stalled
                    if (!stall_i) begin
                        data_valid_o     = 1'b1;
                        misaligned_o     = misaligned;
                        illegal_access_o = illegal;
                    end else begin
                        save_en  = 1'b1;
                        save_mis = misaligned;
                        save_ill = illegal;
                        state_d  = WAIT_STALL;
                    end
                end else if (valid_operation_i && operation_i == lsu_pkg::LDW) begin
                    if (foward_match_i) begin
                        // Forwarded word is released on the next cycle
                        save_en   = 1'b1;
                        save_data = foward_data_i;
                        state_d   = WAIT_STALL;
                    end else begin
                        mem_request_o = 1'b1;
                        state_d       = WAIT_MEMORY;
                    end
                end else if (valid_operation_i) begin
                    // Sub-word loads see memory only once every store has drained
                    state_d = WAIT_BUFFER_DRAIN;
                end
            end
            WAIT_BUFFER_DRAIN: begin
                if (buffer_empty_i) begin
                    mem_request_o = 1'b1;
                    state_d       = WAIT_MEMORY;
                end
            end
            WAIT_MEMORY: begin
                data_selected = mem_data_i;
                if (mem_valid_i && !stall_i) begin
                    data_valid_o = 1'b1;
                    state_d      = IDLE;
                end else if (mem_valid_i) begin
                    // Late response is kept until the stall ends
                    save_en = 1'b1;
                    state_d = WAIT_STALL;
                end
            end
            WAIT_STALL: begin
                data_selected = saved_data_q;
                if (!stall_i) begin
                    data_valid_o     = 1'b1;
                    misaligned_o     = saved_mis_q;
                    illegal_access_o = saved_ill_q;
                    state_d          = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end : fsm_logic

    assign idle_o = (state_q == IDLE);

    // ------------------------------------------------------------
    // Slicing and extension on the registered offset
    // ------------------------------------------------------------

    assign byte_sel = data_selected[8*address_q[1:0] +: 8];
    assign half_sel = data_selected[16*address_q[1] +: 16];

    always_comb begin
        case (operation_q)
            lsu_pkg::LDB: data_sliced = {{24{signed_q & byte_sel[7]}}, byte_sel};
            lsu_pkg::LDH: data_sliced = {{16{signed_q & half_sel[15]}}, half_sel};
            default:      data_sliced = data_selected;
        endcase
    end

    // A faulting load returns zero
    assign data_loaded_o = (misaligned_o | illegal_access_o) ? '0 : data_sliced;

endmodule : load_unit

/* lsu_top.sv */
// ------------------------------------------------------------
// Load and store path top level: load unit, store buffer,
// data memory and the memory port arbitration
// ------------------------------------------------------------

`timescale 1ns/10ps

module lsu_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                privilege_i,
    input  logic                load_valid_i,
    input  lsu_pkg::data_word_t load_address_i,
    input  lsu_pkg::ldu_uop_e   load_uop_i,
    input  logic                load_signed_i,
    input  logic                store_valid_i,
    input  lsu_pkg::data_word_t store_address_i,
    input  lsu_pkg::data_word_t store_data_i,
    output lsu_pkg::data_word_t data_loaded_o,
    output logic                data_valid_o,
    output logic                misaligned_o,
    output logic                illegal_access_o,
    output logic                idle_o,
    output logic                store_full_o,
    output logic                buffer_empty_o
);

    logic                foward_match, buffer_empty;
    lsu_pkg::data_word_t foward_data;
    logic                mem_read_req, mem_read_valid;
    lsu_pkg::data_word_t mem_read_addr, mem_read_data;
    logic                drain_req, drain_grant;
    lsu_pkg::data_word_t drain_addr, drain_data;
    logic                read_busy_q;

    // Read in flight from the strobe until its valid pulse
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            read_busy_q <= 1'b0;
        end else if (mem_read_req) begin
            read_busy_q <= 1'b1;
        end else if (mem_read_valid) begin
            read_busy_q <= 1'b0;
        end
    end

    // Reads win the port, a drain only goes out when no read is active
    assign drain_grant    = drain_req & ~mem_read_req & ~read_busy_q;
    assign buffer_empty_o = buffer_empty;

    load_unit u_load_unit (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall_i), .privilege_i(privilege_i),
        .valid_operation_i(load_valid_i), .load_address_i(load_address_i),
        .operation_i(load_uop_i), .signed_load_i(load_signed_i),
        .foward_match_i(foward_match), .foward_data_i(foward_data),
        .buffer_empty_i(buffer_empty), .mem_valid_i(mem_read_valid),
        .mem_data_i(mem_read_data), .mem_request_o(mem_read_req),
        .mem_address_o(mem_read_addr), .data_loaded_o(data_loaded_o),
        .data_valid_o(data_valid_o), .misaligned_o(misaligned_o),
        .illegal_access_o(illegal_access_o), .idle_o(idle_o)
    );

    // The search runs on the incoming load address
    store_buffer u_store_buffer (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .push_i(store_valid_i),
        .push_addr_i(store_address_i), .push_data_i(store_data_i),
        .search_addr_i(load_address_i), .drain_grant_i(drain_grant),
        .drain_req_o(drain_req), .drain_addr_o(drain_addr), .drain_data_o(drain_data),
        .foward_match_o(foward_match), .foward_data_o(foward_data),
        .full_o(store_full_o), .empty_o(buffer_empty)
    );

    data_memory u_data_memory (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .read_req_i(mem_read_req),
        .read_addr_i(mem_read_addr), .write_i(drain_grant), .write_addr_i(drain_addr),
        .write_data_i(drain_data), .read_valid_o(mem_read_valid),
        .read_data_o(mem_read_data)
    );

endmodule : lsu_top

/* tb_lsu.sv */
// ------------------------------------------------------------
// Testbench for the load and store path with a stim file
// driver, a random stall source and a load result checker
// ------------------------------------------------------------

`timescale 1ns/10ps

module tb_lsu;

    localparam int STIM_MAX = 64;

    logic                clk_i   = 1'b0;
    logic                stall_i = 1'b0;
    logic                rst_n_i;
    logic                privilege_i;
    logic                load_valid_i;
    lsu_pkg::data_word_t load_address_i;
    lsu_pkg::ldu_uop_e   load_uop_i;
    logic                load_signed_i;
    logic                store_valid_i;
    lsu_pkg::data_word_t store_address_i;
    lsu_pkg::data_word_t store_data_i;
    lsu_pkg::data_word_t data_loaded_o;
    logic                data_valid_o;
    logic                misaligned_o;
    logic                illegal_access_o;
    logic                idle_o;
    logic                store_full_o;
    logic                buffer_empty_o;

    // Parsed stim lines whose fields depend on the opcode
    logic [7:0]  stim_op   [STIM_MAX];
    int          stim_line [STIM_MAX];
    logic [31:0] stim_f    [STIM_MAX][7];
    int          stim_count  = 0;
    logic        stim_ok     = 1'b0;
    int          stim_errors = 0;

    // Expected results in issue order with one entry per load strobe
    lsu_pkg::data_word_t exp_data [STIM_MAX];
    logic                exp_mis  [STIM_MAX];
    logic                exp_ill  [STIM_MAX];
    int                  exp_line [STIM_MAX];
    int                  issued_count  = 0;
    int                  checked_count = 0;
    int                  error_count   = 0;
    logic                last_was_load = 1'b0;

    // What the previous sample point saw, for the checks one cycle later
    logic                result_prev = 1'b0;
    logic                store_prev  = 1'b0;

    int          cycle_count = 0;
    int          cycle_limit = 100000;
    logic [15:0] lfsr_q;
    logic        stall_bit_a;
    logic        stall_bit_b;

    lsu_top u_lsu_top (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall_i), .privilege_i(privilege_i),
        .load_valid_i(load_valid_i), .load_address_i(load_address_i),
        .load_uop_i(load_uop_i), .load_signed_i(load_signed_i),
        .store_valid_i(store_valid_i), .store_address_i(store_address_i),
        .store_data_i(store_data_i), .data_loaded_o(data_loaded_o),
        .data_valid_o(data_valid_o), .misaligned_o(misaligned_o),
        .illegal_access_o(illegal_access_o), .idle_o(idle_o),
        .store_full_o(store_full_o), .buffer_empty_o(buffer_empty_o)
    );

    always #4 clk_i = ~clk_i;

    // Maximal length 16-bit Galois LFSR whose output bit is bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        lfsr_step = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    // Two bits ANDed give a stall on about one cycle in four
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q = 16'd24;
            stall_i <= 1'b0;
        end else begin
            stall_bit_a = lfsr_q[0];
            lfsr_q      = lfsr_step(lfsr_q);
            stall_bit_b = lfsr_q[0];
            lfsr_q      = lfsr_step(lfsr_q);
            stall_i <= stall_bit_a & stall_bit_b;
        end
    end

    // ------------------------------------------------------------
    // Result checker sampling at the falling edge where outputs are stable
    // ------------------------------------------------------------

    always @(negedge clk_i) begin
        // Every result leaves the unit idle and ready on the next cycle
        if (result_prev && !idle_o) begin
            $display("FAILED idle_o cycle %0d: got %h expected %h",
                     cycle_count, idle_o, 1'b1);
            error_count = error_count + 1;
        end
        // A store accepted in the previous cycle is now held in the buffer
        if (store_prev && buffer_empty_o) begin
            $display("FAILED buffer_empty_o cycle %0d: got %h expected %h",
                     cycle_count, buffer_empty_o, 1'b0);
            error_count = error_count + 1;
        end
        result_prev = rst_n_i && data_valid_o;
        store_prev  = rst_n_i && store_valid_i && !store_full_o;
        if (rst_n_i && data_valid_o) begin
            if (stall_i) begin
                $display("A result was presented while stall_i was high, cycle %0d", cycle_count);
                error_count = error_count + 1;
            end
            if (checked_count >= issued_count) begin
                $display("A result arrived with no load outstanding, cycle %0d", cycle_count);
                error_count = error_count + 1;
            end else begin
                if (data_loaded_o !== exp_data[checked_count]) begin
                    $display("FAILED data_loaded_o stim line %0d: got %h expected %h",
                             exp_line[checked_count], data_loaded_o, exp_data[checked_count]);
                    error_count = error_count + 1;
                end
                if (misaligned_o !== exp_mis[checked_count]) begin
                    $display("FAILED misaligned_o stim line %0d: got %h expected %h",
                             exp_line[checked_count], misaligned_o, exp_mis[checked_count]);
                    error_count = error_count + 1;
                end
                if (illegal_access_o !== exp_ill[checked_count]) begin
                    $display("FAILED illegal_access_o stim line %0d: got %h expected %h",
                             exp_line[checked_count], illegal_access_o, exp_ill[checked_count]);
                    error_count = error_count + 1;
                end
                checked_count = checked_count + 1;
            end
        end
    end

    // The limit covers the slowest line with a wide margin
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("Loads checked: %0d, errors: %0d", checked_count,
                     error_count + stim_errors + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------

    // Lines starting with # are column notes
    task automatic read_stim_file();
        int    fd;
        int    line_no;
        int    n;
        string line;
        line_no = 0;
        fd = $fopen("lsu_stim.txt", "r");
        if (fd != 0) begin
            stim_ok = 1'b1;
            while (!$feof(fd) && stim_count < STIM_MAX) begin
                line    = "";
                n       = $fgets(line, fd);
                line_no = line_no + 1;
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    stim_op[stim_count]   = line[0];
                    stim_line[stim_count] = line_no;
                    for (int k = 0; k < 7; k++) begin
                        stim_f[stim_count][k] = '0;
                    end
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                                stim_f[stim_count][0], stim_f[stim_count][1],
                                stim_f[stim_count][2], stim_f[stim_count][3],
                                stim_f[stim_count][4], stim_f[stim_count][5],
                                stim_f[stim_count][6]);
                    stim_count = stim_count + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    // Drops both strobes and waits for the next sample point
    task automatic idle_one_cycle();
        @(posedge clk_i);
        store_valid_i <= 1'b0;
        load_valid_i  <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic issue_store(input int idx);
        while (store_full_o) begin
            idle_one_cycle();
        end
        @(posedge clk_i);
        store_valid_i   <= 1'b1;
        store_address_i <= stim_f[idx][0];
        store_data_i    <= stim_f[idx][1];
        load_valid_i    <= 1'b0;
        @(negedge clk_i);
        last_was_load = 1'b0;
    endtask

    // A load right after a load would see a stale idle_o, so one gap cycle is added
    task automatic issue_load(input int idx);
        if (last_was_load) begin
            idle_one_cycle();
        end
        while (!idle_o) begin
            idle_one_cycle();
        end
        @(posedge clk_i);
        exp_data[issued_count] = stim_f[idx][4];
        exp_mis[issued_count]  = stim_f[idx][5][0];
        exp_ill[issued_count]  = stim_f[idx][6][0];
        exp_line[issued_count] = stim_line[idx];
        issued_count = issued_count + 1;
        load_valid_i   <= 1'b1;
        load_address_i <= stim_f[idx][0];
        load_uop_i     <= lsu_pkg::ldu_uop_e'(stim_f[idx][1][1:0]);
        load_signed_i  <= stim_f[idx][2][0];
        privilege_i    <= stim_f[idx][3][0];
        store_valid_i  <= 1'b0;
        @(negedge clk_i);
        last_was_load = 1'b1;
    endtask

    // One cycle first so that a store strobed just before is counted
    task automatic wait_buffer_drained();
        idle_one_cycle();
        while (!buffer_empty_o) begin
            idle_one_cycle();
        end
        last_was_load = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        rst_n_i         = 1'b0;
        privilege_i     = 1'b0;
        load_valid_i    = 1'b0;
        load_address_i  = '0;
        load_uop_i      = lsu_pkg::LDW;
        load_signed_i   = 1'b0;
        store_valid_i   = 1'b0;
        store_address_i = '0;
        store_data_i    = '0;
        read_stim_file();
        if (!stim_ok) begin
            $display("The stim file lsu_stim.txt could not be opened");
            $display("Done: errors found");
            $finish;
        end else begin
            cycle_limit = 64 * stim_count + 200;
            repeat (16) @(posedge clk_i);
            rst_n_i <= 1'b1;
            @(negedge clk_i);
            while (!(idle_o && buffer_empty_o)) begin
                idle_one_cycle();
            end
            for (int i = 0; i < stim_count; i++) begin
                case (stim_op[i])
                    "S":     issue_store(i);
                    "L":     issue_load(i);
                    "D":     wait_buffer_drained();
                    default: begin
                        $display("Unknown opcode on stim line %0d", stim_line[i]);
                        stim_errors = stim_errors + 1;
                    end
                endcase
            end
            // Every issued load must come back before the summary
            idle_one_cycle();
            while (checked_count != issued_count) begin
                idle_one_cycle();
            end
            $display("Loads checked: %0d, errors: %0d", checked_count,
                     error_count + stim_errors);
            if (error_count + stim_errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule : tb_lsu

/* lsu_stim.txt */
# S addr data | L addr size(0 byte, 1 half, 2 word) signed privilege data misaligned illegal
# D waits until the store buffer is empty, all fields are hex
S 00000040 CAFEF00D
D
S 00000044 11112222
L 00000044 2 0 0 11112222 0 0
L 00000040 2 0 0 CAFEF00D 0 0
S 00000048 33334444
S 00000050 AAAA0001
S 00000050 BBBB0002
L 00000050 2 0 0 BBBB0002 0 0
S 00000100 F1807F02
L 00000100 0 0 0 00000002 0 0
L 00000101 0 1 0 0000007F 0 0
L 00000102 0 1 0 FFFFFF80 0 0
L 00000103 0 0 0 000000F1 0 0
L 00000100 1 1 0 00007F02 0 0
L 00000102 1 1 0 FFFFF180 0 0
S 00000104 00FF8001
L 00000104 0 1 0 00000001 0 0
L 00000105 0 0 0 00000080 0 0
L 00000106 0 1 0 FFFFFFFF 0 0
L 00000107 0 1 0 00000000 0 0
L 00000104 1 0 0 00008001 0 0
L 00000106 1 0 0 000000FF 0 0
L 00000104 1 1 0 FFFF8001 0 0
L 00000101 1 0 0 00000000 1 0
L 00000041 2 0 0 00000000 1 0
L 00000042 2 0 0 00000000 1 0
L 00000043 2 0 0 00000000 1 0
S 00000384 5EC00001
D
L 00000384 2 0 0 00000000 0 1
L 00000384 2 0 1 5EC00001 0 0
L 00000386 1 1 0 00000000 0 1
L 00000386 1 1 1 00005EC0 0 0

/* all.f */
lsu_pkg.sv
store_buffer.sv
data_memory.sv
load_unit.sv
lsu_top.sv
tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# Builds the load and store path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_lsu -f all.f -o sim_lsu \
    && ./obj_dir/sim_lsu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
